//--- verilog.f
+incdir+include
source/rvc_pkg.sv
source/rvc_quadrant0.sv
source/rvc_quadrant1.sv
source/rvc_quadrant2.sv
source/rvc_expand_stage.sv
source/rvc_expander.sv
verif/rvc_expander_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the expander testbench with Verilator.
rm -f sim.log
verilator --binary --assert --timing --top-module rvc_expander_tb \
    -f verilog.f -o rvc_expander_sim > build.log 2>&1 \
    && ./obj_dir/rvc_expander_sim > sim.log 2>&1
grep -q "^RESULT: PASS$" sim.log && echo "simulation passed" \
    || { echo "simulation failed, see build.log and sim.log"; exit 1; }

//--- include/rvc_vectors.svh
`ifndef RVC_VECTORS_SVH
`define RVC_VECTORS_SVH

// each entry is {halfword[15:0], expected expansion[31:0], expected illegal flag}.
// the expansions follow the RV32C to RV32I mapping of the ratified C extension.

localparam int NUM_VECTORS = 39;

localparam logic [48:0] VECTORS [NUM_VECTORS] = '{
    {16'h0040, 32'h00410413, 1'b0},  // c.addi4spn x8, sp, 4.
    {16'h4144, 32'h00452483, 1'b0},  // c.lw x9, 4(x10).
    {16'hc504, 32'h00952423, 1'b0},  // c.sw x9, 8(x10).
    {16'h0001, 32'h00000013, 1'b0},  // c.nop.
    {16'h0005, 32'h00100013, 1'b0},  // c.addi x0, 1 is a hint.
    {16'h157d, 32'hfff50513, 1'b0},  // c.addi x10, -1.
    {16'h4595, 32'h00500593, 1'b0},  // c.li x11, 5.
    {16'h6141, 32'h01010113, 1'b0},  // c.addi16sp 16.
    {16'h6285, 32'h000012b7, 1'b0},  // c.lui x5, 1.
    {16'h800d, 32'h00345413, 1'b0},  // c.srli x8, 3.
    {16'h8485, 32'h4014d493, 1'b0},  // c.srai x9, 1.
    {16'h9979, 32'hffe57513, 1'b0},  // c.andi x10, -2.
    {16'h8c05, 32'h40940433, 1'b0},  // c.sub x8, x9.
    {16'h8c25, 32'h00944433, 1'b0},  // c.xor x8, x9.
    {16'h8c45, 32'h00946433, 1'b0},  // c.or x8, x9.
    {16'h8c65, 32'h00947433, 1'b0},  // c.and x8, x9.
    {16'h0512, 32'h00451513, 1'b0},  // c.slli x10, 4.
    {16'h45a2, 32'h00812583, 1'b0},  // c.lwsp x11, 8.
    {16'hc632, 32'h00c12623, 1'b0},  // c.swsp x12, 12.
    {16'h8082, 32'h00008067, 1'b0},  // c.jr ra.
    {16'h9282, 32'h000280e7, 1'b0},  // c.jalr x5.
    {16'h852e, 32'h00b00533, 1'b0},  // c.mv x10, x11.
    {16'h952e, 32'h00b50533, 1'b0},  // c.add x10, x11.
    {16'h9002, 32'h00100073, 1'b0},  // c.ebreak.

    // Reserved, RV64-only and dropped encodings.
    {16'h0000, 32'h00000000, 1'b1},
    {16'h0004, 32'h00000000, 1'b1},  // addi4spn with zero immediate.
    {16'h4002, 32'h00000000, 1'b1},  // lwsp with rd = 0.
    {16'h6101, 32'h00000000, 1'b1},  // addi16sp with zero immediate.
    {16'h6281, 32'h00000000, 1'b1},  // lui with zero immediate.
    {16'h8002, 32'h00000000, 1'b1},  // jr with rs1 = 0.
    {16'h900d, 32'h00000000, 1'b1},  // srli with shamt[5].
    {16'h9485, 32'h00000000, 1'b1},  // srai with shamt[5].
    {16'h1512, 32'h00000000, 1'b1},  // slli with shamt[5].
    {16'h9c05, 32'h00000000, 1'b1},  // subw slot.
    {16'ha001, 32'h00000000, 1'b1},  // c.j.
    {16'h2001, 32'h00000000, 1'b1},  // c.jal.
    {16'hc001, 32'h00000000, 1'b1},  // c.beqz.
    {16'he001, 32'h00000000, 1'b1},  // c.bnez.
    {16'h0003, 32'h00000000, 1'b1}   // quadrant 3.
};

`endif

//--- verif/rvc_expander_tb.sv
`timescale 1ns/1ps

module rvc_expander_tb;

    localparam real         CLK_PERIOD   = 4.0;
    localparam int          SHAPE_COUNT  = 40;
    localparam int          Q3_COUNT     = 8;
    localparam int          PRIME_COUNT  = 16;
    localparam logic [31:0] SEED         = 32'h4d5b_646d;

    `include "rvc_vectors.svh"

    // every send may be followed by one idle cycle.
    localparam int WATCHDOG_CYCLES = 2 * (NUM_VECTORS + SHAPE_COUNT + Q3_COUNT + PRIME_COUNT) + 20;

    typedef struct {
        string       name;
        bit          exact;   // full compare, else only the shape of the result.
        logic [31:0] instr;
        logic        illegal;
    } expect_t;

    logic        clk_i;
    logic        rst_n_i;
    logic        valid_i;
    logic [15:0] cinstr_i;
    logic        valid_o;
    logic [32:0] result_o;
    logic [31:0] lfsr;
    logic        sampled_valid;
    logic        sampled_rst;
    expect_t     pending [$];

    rvc_expander rvc_expander_i (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .valid_i  (valid_i),
        .cinstr_i (cinstr_i),
        .valid_o  (valid_o),
        .result_o (result_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    task automatic fail_value(input string test, input logic [31:0] expected,
                              input logic [31:0] actual);
        $display("FAIL %s expected %h actual %h", test, expected, actual);
        $display("RESULT: FAIL");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic fail_plain(input string what);
        $display("%s", what);
        $display("RESULT: FAIL");
        $fatal(1, "stopped at the first error");
    endtask

    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        return state[0] ? ((state >> 1) ^ 32'h8020_0003) : (state >> 1);
    endfunction

    task automatic take_bits(input int count, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsr  = lfsr_step(lfsr);
            value = {value[30:0], lfsr[0]};
        end
    endtask

    task automatic send(input logic [15:0] halfword, input expect_t entry);
        logic [31:0] gap;
        logic [31:0] junk;
        @(posedge clk_i);
        #0.5;
        valid_i  = 1'b1;
        cinstr_i = halfword;
        pending.push_back(entry);
        take_bits(1, gap);
        if (gap[0]) begin // a bubble, otherwise the next send is back to back.
            take_bits(16, junk);
            @(posedge clk_i);
            #0.5;
            valid_i  = 1'b0;
            cinstr_i = junk[15:0]; // a halfword in a bubble must not reach result_o.
        end
    endtask

    //////////////////////////////////////////////////
    // checking
    //////////////////////////////////////////////////

    always @(posedge clk_i) begin
        sampled_valid <= valid_i;
        sampled_rst   <= rst_n_i;
    end

    // result_o only moves on an edge that also raises valid_o.
    assert property (@(posedge clk_i)
        (rst_n_i && $past(rst_n_i) && !valid_o) |-> $stable(result_o))
        else fail_plain("result_o changed while valid_o was low");

    always @(negedge clk_i) begin
        expect_t entry;
        if (sampled_rst === 1'b0) begin
            assert (valid_o == 1'b0) else fail_value("reset valid", 32'd0, {31'd0, valid_o});
            assert (result_o == '0) else fail_value("reset result", 32'd0, result_o[32:1]);
        end else if (sampled_rst === 1'b1) begin
            assert (valid_o == sampled_valid)
                else fail_value("valid timing", {31'd0, sampled_valid}, {31'd0, valid_o});
        end
        if (valid_o) begin
            assert (pending.size() != 0) else fail_plain("valid_o rose with nothing sent");
            entry = pending.pop_front();
            if (entry.exact) begin
                assert (result_o[32:1] == entry.instr)
                    else fail_value(entry.name, entry.instr, result_o[32:1]);
                assert (result_o[0] == entry.illegal)
                    else fail_value({entry.name, " illegal"}, {31'd0, entry.illegal},
                                    {31'd0, result_o[0]});
            end else if (result_o[0]) begin
                assert (result_o[32:1] == '0)
                    else fail_value(entry.name, 32'd0, result_o[32:1]);
            end else begin
                assert (result_o[2:1] == 2'b11)
                    else fail_value(entry.name, 32'd3, {30'd0, result_o[2:1]});
            end
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        fail_plain("the simulation hung before all results came back");
    end

    //////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////

    initial begin
        logic [31:0] bits;
        logic [31:0] op;
        logic [31:0] rdp;
        logic [31:0] rs2p;
        logic [2:0]  f3;
        expect_t     entry;

        rst_n_i  = 1'b0;
        valid_i  = 1'b1; // a valid c.nop during reset must not get through.
        cinstr_i = 16'h0001;
        lfsr     = SEED;
        repeat (4) @(posedge clk_i);
        #0.5;
        rst_n_i = 1'b1;
        valid_i = 1'b0;

        for (int i = 0; i < NUM_VECTORS; i++) begin
            entry = '{$sformatf("directed %h", VECTORS[i][48:33]), 1'b1,
                      VECTORS[i][32:1], VECTORS[i][0]};
            send(VECTORS[i][48:33], entry);
        end

        for (int i = 0; i < SHAPE_COUNT; i++) begin
            take_bits(16, bits);
            bits[1:0] = bits[1:0] % 3; // quadrants 0 to 2 only.
            entry = '{$sformatf("shape %h", bits[15:0]), 1'b0, 32'd0, 1'b0};
            send(bits[15:0], entry);
        end

        for (int i = 0; i < Q3_COUNT; i++) begin
            take_bits(14, bits);
            entry = '{$sformatf("quadrant3 %h", {bits[13:0], 2'b11}), 1'b1, 32'd0, 1'b1};
            send({bits[13:0], 2'b11}, entry);
        end

        for (int i = 0; i < PRIME_COUNT; i++) begin
            op = i % 4;
            take_bits(3, rdp);
            take_bits(3, rs2p);
            case (op[1:0])
                2'b00:   f3 = 3'b000;
                2'b01:   f3 = 3'b100;
                2'b10:   f3 = 3'b110;
                default: f3 = 3'b111;
            endcase
            entry.name    = $sformatf("prime op%0d x%0d x%0d", op, 8 + rdp, 8 + rs2p);
            entry.exact   = 1'b1;
            entry.illegal = 1'b0;
            entry.instr   = {(op == 0) ? 7'b0100000 : 7'b0000000, 5'(8 + rs2p),
                             5'(8 + rdp), f3, 5'(8 + rdp), 7'b0110011};
            send({3'b100, 1'b0, 2'b11, rdp[2:0], op[1:0], rs2p[2:0], 2'b01}, entry);
        end

        @(posedge clk_i);
        #0.5;
        valid_i = 1'b0;
        while (pending.size() != 0) begin
            @(posedge clk_i);
        end
        @(negedge clk_i);
        $display("RESULT: PASS");
        $finish;
    end

endmodule

//--- source/rvc_expander.sv
`timescale 1ns/1ps

module rvc_expander import rvc_pkg::*; (
    input  logic           clk_i,
    input  logic           rst_n_i,
    input  logic           valid_i,
    input  cinstr_t        cinstr_i,
    output logic           valid_o,
    output expand_result_t result_o
);

    expand_result_t q0_result;
    expand_result_t q1_result;
    expand_result_t q2_result;

    // all three decoders see every halfword. The stage picks one.
    rvc_quadrant0 rvc_quadrant0_i (
        .cinstr_i (cinstr_i),
        .result_o (q0_result)
    );

    rvc_quadrant1 rvc_quadrant1_i (
        .cinstr_i (cinstr_i),
        .result_o (q1_result)
    );

    rvc_quadrant2 rvc_quadrant2_i (
        .cinstr_i (cinstr_i),
        .result_o (q2_result)
    );

    rvc_expand_stage rvc_expand_stage_i (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .valid_i     (valid_i),
        .cinstr_i    (cinstr_i),
        .q0_result_i (q0_result),
        .q1_result_i (q1_result),
        .q2_result_i (q2_result),
        .valid_o     (valid_o),
        .result_o    (result_o)
    );

endmodule

//--- source/rvc_expand_stage.sv
`timescale 1ns/1ps

module rvc_expand_stage import rvc_pkg::*; (
    input  logic           clk_i,
    input  logic           rst_n_i,
    input  logic           valid_i,
    input  cinstr_t        cinstr_i,
    input  expand_result_t q0_result_i,
    input  expand_result_t q1_result_i,
    input  expand_result_t q2_result_i,
    output logic           valid_o,
    output expand_result_t result_o
);

    expand_result_t selected;
    expand_result_t cleaned;

    //////////////////////////////////////////////////
    // quadrant select
    //////////////////////////////////////////////////

    always_comb begin
        case (cinstr_i.full.quadrant)
            2'b00: selected = q0_result_i;
            2'b01: selected = q1_result_i;
            2'b10: selected = q2_result_i;
            default: begin
                // a full 32-bit instruction should never reach this unit.
                selected.instr   = '0;
                selected.illegal = 1'b1;
            end
        endcase
    end

    always_comb begin
        cleaned = selected;
        if (selected.illegal) begin
            cleaned.instr = '0; // no partial expansion leaks downstream.
        end
    end

    //////////////////////////////////////////////////
    // output register
    //////////////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            valid_o  <= 1'b0;
            result_o <= '0;
        end else begin
            valid_o <= valid_i;
            if (valid_i) begin
                result_o <= cleaned; // holds across bubbles.
            end
        end
    end

endmodule

//--- source/rvc_quadrant2.sv
`timescale 1ns/1ps

module rvc_quadrant2 import rvc_pkg::*; (
    input  cinstr_t        cinstr_i,
    output expand_result_t result_o
);

    logic [5:0] shamt;
    logic [7:0] lwsp_imm;
    logic [7:0] swsp_imm;
    logic       rd_zero;
    logic       rs2_zero;

    assign shamt    = {cinstr_i.raw[12], cinstr_i.raw[6:2]};
    assign lwsp_imm = {cinstr_i.raw[3:2], cinstr_i.raw[12], cinstr_i.raw[6:4], 2'b00};
    assign swsp_imm = {cinstr_i.raw[8:7], cinstr_i.raw[12:9], 2'b00};
    assign rd_zero  = (cinstr_i.full.rd == REG_ZERO);
    assign rs2_zero = (cinstr_i.full.rs2 == REG_ZERO);

    always_comb begin
        result_o = '0;

        case (cinstr_i.full.funct3)
            3'b000: begin // C.SLLI.
                result_o.instr.rs2    = shamt[4:0];
                result_o.instr.rs1    = cinstr_i.full.rd;
                result_o.instr.funct3 = F3_SLL;
                result_o.instr.rd     = cinstr_i.full.rd;
                result_o.instr.opcode = OP_IMM;
                result_o.illegal      = shamt[5];
            end

            3'b010: begin // C.LWSP.
                {result_o.instr.funct7, result_o.instr.rs2} = {4'b0, lwsp_imm};
                result_o.instr.rs1    = REG_SP;
                result_o.instr.funct3 = F3_LW_SW;
                result_o.instr.rd     = cinstr_i.full.rd;
                result_o.instr.opcode = LOAD;
                result_o.illegal      = rd_zero;
            end

            3'b110: begin // C.SWSP.
                {result_o.instr.funct7, result_o.instr.rd} = {4'b0, swsp_imm};
                result_o.instr.rs2    = cinstr_i.full.rs2;
                result_o.instr.rs1    = REG_SP;
                result_o.instr.funct3 = F3_LW_SW;
                result_o.instr.opcode = STORE;
            end

            3'b100: begin
                if (!cinstr_i.full.bit12) begin
                    if (rs2_zero) begin // C.JR is jalr x0, 0(rs1).
                        result_o.instr.rs1    = cinstr_i.full.rd;
                        result_o.instr.rd     = REG_ZERO;
                        result_o.instr.opcode = JALR;
                        result_o.illegal      = rd_zero;
                    end else begin // C.MV is add rd, x0, rs2.
                        result_o.instr.rs2    = cinstr_i.full.rs2;
                        result_o.instr.rs1    = REG_ZERO;
                        result_o.instr.funct3 = F3_ADD_SUB;
                        result_o.instr.rd     = cinstr_i.full.rd;
                        result_o.instr.opcode = OP;
                    end
                end else if (rs2_zero) begin
                    if (rd_zero) begin
                        result_o.instr.rs2    = 5'd1; // imm = 1 marks ebreak.
                        result_o.instr.opcode = SYSTEM;
                    end else begin // C.JALR links through ra.
                        result_o.instr.rs1    = cinstr_i.full.rd;
                        result_o.instr.rd     = REG_RA;
                        result_o.instr.opcode = JALR;
                    end
                end else begin // C.ADD.
                    result_o.instr.rs2    = cinstr_i.full.rs2;
                    result_o.instr.rs1    = cinstr_i.full.rd;
                    result_o.instr.funct3 = F3_ADD_SUB;
                    result_o.instr.rd     = cinstr_i.full.rd;
                    result_o.instr.opcode = OP;
                end
            end

            default: result_o.illegal = 1'b1;
        endcase
    end

endmodule

//--- source/rvc_quadrant1.sv
`timescale 1ns/1ps

module rvc_quadrant1 import rvc_pkg::*; (
    input  cinstr_t        cinstr_i,
    output expand_result_t result_o
);

    logic [5:0]  ci_imm;
    logic [11:0] ci_simm;
    logic [9:0]  addi16sp_imm;
    logic [19:0] lui_imm;
    logic [4:0]  rd_prime;

    assign ci_imm  = {cinstr_i.raw[12], cinstr_i.raw[6:2]};
    assign ci_simm = {{6{ci_imm[5]}}, ci_imm};

    // nzimm[9] in bit 12, nzimm[4|6|8:7|5] in bits 6:2.
    assign addi16sp_imm = {cinstr_i.raw[12], cinstr_i.raw[4:3], cinstr_i.raw[5],
                           cinstr_i.raw[2], cinstr_i.raw[6], 4'b0000};

    assign lui_imm  = {{14{ci_imm[5]}}, ci_imm}; // nzimm[17:12] sign extended.
    assign rd_prime = prime_reg(cinstr_i.prime.rd_p);

    always_comb begin
        result_o = '0;

        case (cinstr_i.full.funct3)
            3'b000: begin // C.NOP and C.ADDI.
                {result_o.instr.funct7, result_o.instr.rs2} = ci_simm;
                result_o.instr.rs1    = cinstr_i.full.rd;
                result_o.instr.funct3 = F3_ADD_SUB;
                result_o.instr.rd     = cinstr_i.full.rd;
                result_o.instr.opcode = OP_IMM;
            end

            3'b010: begin // C.LI.
                {result_o.instr.funct7, result_o.instr.rs2} = ci_simm;
                result_o.instr.rs1    = REG_ZERO;
                result_o.instr.funct3 = F3_ADD_SUB;
                result_o.instr.rd     = cinstr_i.full.rd;
                result_o.instr.opcode = OP_IMM;
            end

            3'b011: begin
                if (cinstr_i.full.rd == REG_SP) begin // C.ADDI16SP.
                    {result_o.instr.funct7, result_o.instr.rs2} =
                        {{2{addi16sp_imm[9]}}, addi16sp_imm};
                    result_o.instr.rs1    = REG_SP;
                    result_o.instr.funct3 = F3_ADD_SUB;
                    result_o.instr.rd     = REG_SP;
                    result_o.instr.opcode = OP_IMM;
                    result_o.illegal      = (addi16sp_imm == '0);
                end else begin // C.LUI.
                    {result_o.instr.funct7, result_o.instr.rs2,
                     result_o.instr.rs1, result_o.instr.funct3} = lui_imm;
                    result_o.instr.rd     = cinstr_i.full.rd;
                    result_o.instr.opcode = LUI;
                    result_o.illegal      = (ci_imm == '0);
                end
            end

            3'b100: begin
                result_o.instr.rs1 = rd_prime;
                result_o.instr.rd  = rd_prime;

                case (cinstr_i.prime.sub)
                    2'b00: begin // C.SRLI.
                        result_o.instr.funct7 = '0;
                        result_o.instr.rs2    = ci_imm[4:0];
                        result_o.instr.funct3 = F3_SRL_SRA;
                        result_o.instr.opcode = OP_IMM;
                        result_o.illegal      = cinstr_i.raw[12]; // shamt[5] on RV32.
                    end

                    2'b01: begin // C.SRAI.
                        result_o.instr.funct7 = F7_ALT;
                        result_o.instr.rs2    = ci_imm[4:0];
                        result_o.instr.funct3 = F3_SRL_SRA;
                        result_o.instr.opcode = OP_IMM;
                        result_o.illegal      = cinstr_i.raw[12];
                    end

                    2'b10: begin // C.ANDI.
                        {result_o.instr.funct7, result_o.instr.rs2} = ci_simm;
                        result_o.instr.funct3 = F3_AND;
                        result_o.instr.opcode = OP_IMM;
                    end

                    default: begin
                        result_o.instr.rs2    = prime_reg(cinstr_i.prime.rs2_p);
                        result_o.instr.opcode = OP;

                        case (cinstr_i.prime.op2)
                            2'b00: begin // C.SUB.
                                result_o.instr.funct7 = F7_ALT;
                                result_o.instr.funct3 = F3_ADD_SUB;
                            end
                            2'b01: result_o.instr.funct3 = F3_XOR;
                            2'b10: result_o.instr.funct3 = F3_OR;
                            default: result_o.instr.funct3 = F3_AND;
                        endcase

                        // bit 12 set selects the RV64 word forms.
                        result_o.illegal = cinstr_i.prime.bit12;
                    end
                endcase
            end

            // C.JAL, C.J, C.BEQZ and C.BNEZ are not expanded here.
            default: result_o.illegal = 1'b1;
        endcase
    end

endmodule

//--- source/rvc_quadrant0.sv
`timescale 1ns/1ps

module rvc_quadrant0 import rvc_pkg::*; (
    input  cinstr_t        cinstr_i,
    output expand_result_t result_o
);

    logic [9:0] addi4spn_imm;
    logic [6:0] word_imm;

    // nzuimm[5:4|9:6|2|3] sits in bits 12:5.
    assign addi4spn_imm = {cinstr_i.raw[10:7], cinstr_i.raw[12:11],
                           cinstr_i.raw[5], cinstr_i.raw[6], 2'b00};

    // uimm[5:3] in 12:10, uimm[2] in bit 6, uimm[6] in bit 5.
    assign word_imm = {cinstr_i.raw[5], cinstr_i.raw[12:10], cinstr_i.raw[6], 2'b00};

    always_comb begin
        result_o = '0;

        case (cinstr_i.prime.funct3)
            3'b000: begin // C.ADDI4SPN becomes addi rd', sp, nzuimm.
                {result_o.instr.funct7, result_o.instr.rs2} = {2'b00, addi4spn_imm};
                result_o.instr.rs1    = REG_SP;
                result_o.instr.funct3 = F3_ADD_SUB;
                result_o.instr.rd     = prime_reg(cinstr_i.prime.rs2_p);
                result_o.instr.opcode = OP_IMM;
                // also catches the all-zero halfword.
                result_o.illegal      = (addi4spn_imm == '0);
            end

            3'b010: begin // C.LW.
                {result_o.instr.funct7, result_o.instr.rs2} = {5'b0, word_imm};
                result_o.instr.rs1    = prime_reg(cinstr_i.prime.rd_p);
                result_o.instr.funct3 = F3_LW_SW;
                result_o.instr.rd     = prime_reg(cinstr_i.prime.rs2_p);
                result_o.instr.opcode = LOAD;
            end

            3'b110: begin // C.SW.
                {result_o.instr.funct7, result_o.instr.rd} = {5'b0, word_imm};
                result_o.instr.rs2    = prime_reg(cinstr_i.prime.rs2_p);
                result_o.instr.rs1    = prime_reg(cinstr_i.prime.rd_p);
                result_o.instr.funct3 = F3_LW_SW;
                result_o.instr.opcode = STORE;
            end

            // floating point loads and stores and the reserved slot.
            default: result_o.illegal = 1'b1;
        endcase
    end

endmodule

//--- source/rvc_pkg.sv
package rvc_pkg;

    //////////////////////////////////////////////////
    // compressed instruction views
    //////////////////////////////////////////////////

    // CR/CI/CSS layout with full 5-bit register fields.
    typedef struct packed {
        logic [2:0] funct3;   // bits 15:13.
        logic       bit12;
        logic [4:0] rd;       // bits 11:7, also rs1 for CR and CI.
        logic [4:0] rs2;      // bits 6:2.
        logic [1:0] quadrant;
    } cfull_t;

    // CIW/CL/CS/CA/CB layout with 3-bit prime register fields.
    typedef struct packed {
        logic [2:0] funct3;
        logic       bit12;
        logic [1:0] sub;      // bits 11:10 pick the quadrant 1 ALU group.
        logic [2:0] rd_p;     // bits 9:7.
        logic [1:0] op2;      // bits 6:5 pick the CA operation.
        logic [2:0] rs2_p;    // bits 4:2.
        logic [1:0] quadrant;
    } cprime_t;

    typedef union packed {
        logic [15:0] raw;
        cfull_t      full;
        cprime_t     prime;
    } cinstr_t;

    //////////////////////////////////////////////////
    // expanded instruction
    //////////////////////////////////////////////////

    // R-type field layout. The other formats overlay their immediates on it.
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } instr_t;

    typedef struct packed {
        instr_t instr;
        logic   illegal;
    } expand_result_t;

    typedef enum logic [6:0] {
        OP_IMM = 7'b0010011,
        OP     = 7'b0110011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        LUI    = 7'b0110111,
        JALR   = 7'b1100111,
        SYSTEM = 7'b1110011
    } opcode_e;

    //////////////////////////////////////////////////
    // funct fields and registers
    //////////////////////////////////////////////////

    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_LW_SW   = 3'b010;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    localparam logic [6:0] F7_ALT = 7'b0100000; // SUB and SRAI.

    localparam logic [4:0] REG_ZERO = 5'd0;
    localparam logic [4:0] REG_RA   = 5'd1;
    localparam logic [4:0] REG_SP   = 5'd2;

    // prime registers cover x8 to x15.
    function automatic logic [4:0] prime_reg(input logic [2:0] preg);
        return {2'b01, preg};
    endfunction

endpackage
